// ==== ex_stage_top.f ====
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_if.sv
hdl/ex_issue.sv
hdl/ex_compute.sv
hdl/ex_divider.sv
hdl/ex_stage_top.sv
bench/ex_clock_gen.sv
bench/ex_tb.sv

// ==== Makefile ====
# Verilator simulation of the execute stage
# Any variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= ex_tb
FILELIST  ?= ex_stage_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SIM_ARGS  ?=

SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

# Build and run; a $$fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(SIM_EXE) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/ex_tests.mem ====
// op f3 f7b5 rd rs1 rs2 imm pc / result reg_write redirect target misalign
// op 0 alu-reg 1 alu-imm 2 lui 3 auipc 4 branch 5 jal 6 jalr 7 div
0 0 0 01 00000005 00000007 00000000 00001000 0000000c 1 0 00000000 0
0 0 1 02 00000005 00000007 00000000 00001000 fffffffe 1 0 00000000 0
7 4 0 12 ffffffec 00000003 00000000 00000000 fffffffa 1 0 00000000 0
0 1 0 03 00000001 00000024 00000000 00001000 00000010 1 0 00000000 0
0 2 0 04 ffffffff 00000001 00000000 00001000 00000001 1 0 00000000 0
0 3 0 05 ffffffff 00000001 00000000 00001000 00000000 1 0 00000000 0
7 5 0 13 ffffffec 00000003 00000000 00000000 5555554e 1 0 00000000 0
0 4 0 06 f0f0f0f0 ff00ff00 00000000 00001000 0ff00ff0 1 0 00000000 0
0 5 0 07 80000000 00000004 00000000 00001000 08000000 1 0 00000000 0
0 5 1 08 80000000 00000004 00000000 00001000 f8000000 1 0 00000000 0
7 6 0 14 ffffffec 00000003 00000000 00000000 fffffffe 1 0 00000000 0
0 6 0 09 12340000 00005678 00000000 00001000 12345678 1 0 00000000 0
0 7 0 0a 12345678 0000ffff 00000000 00001000 00005678 1 0 00000000 0
0 0 0 00 00000003 00000004 00000000 00001000 00000007 0 0 00000000 0
7 7 0 15 ffffffec 00000003 00000000 00000000 00000002 1 0 00000000 0
1 0 1 0b 00000010 12345678 fffffff0 00001000 00000000 1 0 00000000 0
1 5 1 0c 80000010 00000000 00000401 00001000 c0000008 1 0 00000000 0
1 2 0 0e fffffff0 00000000 ffffffff 00001000 00000001 1 0 00000000 0
1 3 0 0f 00000005 00000000 ffffffff 00001000 00000001 1 0 00000000 0
2 0 0 10 55555555 deadbeef 12345000 00001000 12345000 1 0 00000000 0
3 0 0 11 00000000 00000000 00001000 00000400 00001400 1 0 00000000 0
7 4 0 16 00000064 00000000 00000000 00000000 ffffffff 1 0 00000000 0
4 0 0 03 00000007 00000007 00000010 00000100 00000000 0 1 00000110 0
4 1 0 00 00000007 00000007 00000010 00000100 00000000 0 0 00000000 0
4 4 0 00 ffffffff 00000001 fffffff0 00000200 00000000 0 1 000001f0 0
7 6 0 17 00000064 00000000 00000000 00000000 00000064 1 0 00000000 0
4 5 0 00 ffffffff 00000001 fffffff0 00000200 00000000 0 0 00000000 0
4 6 0 00 ffffffff 00000001 00000008 00000300 00000000 0 0 00000000 0
4 7 0 00 ffffffff 00000001 00000008 00000300 00000000 0 1 00000308 0
4 1 0 00 00000001 00000002 00000006 00000100 00000000 0 1 00000106 1
7 4 0 18 80000000 ffffffff 00000000 00000000 80000000 1 0 00000000 0
5 0 0 01 00000000 00000000 00000800 00001000 00001004 1 1 00001800 0
6 0 0 05 00002001 00000000 00000004 00000040 00000044 1 1 00002004 0
7 6 0 19 80000000 ffffffff 00000000 00000000 00000000 1 0 00000000 0
6 0 0 06 00002002 00000000 00000000 00000080 00000084 0 1 00002002 1
5 0 0 07 00000000 00000000 00000002 00001000 00001004 0 1 00001002 1
7 4 0 00 00000007 fffffffe 00000000 00000000 fffffffd 0 0 00000000 0

// ==== bench/ex_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_tb;
  import ex_pkg::*;

  // ==========================================================
  // Vector layout
  // ==========================================================

  localparam int num_vecs = 37;
  localparam int num_cols = 13;
  localparam int c_op     = 0;
  localparam int c_f3     = 1;
  localparam int c_f7     = 2;
  localparam int c_rd     = 3;
  localparam int c_rs1    = 4;
  localparam int c_rs2    = 5;
  localparam int c_imm    = 6;
  localparam int c_pc     = 7;
  localparam int c_res    = 8;
  localparam int c_wr     = 9;
  localparam int c_redir  = 10;
  localparam int c_tgt    = 11;
  localparam int c_mis    = 12;
  // Bound holds even if every vector were a divide
  localparam int timeout_cycles = 4 * num_vecs * (`EX_DIV_STEPS + 8);

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  op_kind_t    op_kind;
  funct3_t     funct3;
  logic        funct7_b5;
  reg_addr_t   rd_in;
  xlen_t       rs1_data;
  xlen_t       rs2_data;
  xlen_t       imm;
  xlen_t       pc;
  logic        out_valid;
  logic        out_ready;
  reg_addr_t   rd_out;
  xlen_t       result;
  logic        reg_write;
  logic        redirect;
  xlen_t       redirect_tgt;
  logic        misalign;

  logic [31:0] vec_mem [num_vecs * num_cols];
  // Vector indices accepted but not yet seen at the output
  int          exp_q[$];
  int          next_idx;
  int          checked;
  logic        in_fire;
  integer      seed = 32'ha038_1a8b;

  // Output snapshot for the hold check
  logic        stalled;
  reg_addr_t   held_rd;
  xlen_t       held_result;
  logic        held_wr;
  logic        held_redir;
  xlen_t       held_tgt;
  logic        held_mis;

  ex_clock_gen clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_i     (in_valid),
    .in_ready_o     (in_ready),
    .op_kind_i      (op_kind),
    .funct3_i       (funct3),
    .funct7_b5_i    (funct7_b5),
    .rd_i           (rd_in),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .imm_i          (imm),
    .pc_i           (pc),
    .out_valid_o    (out_valid),
    .out_ready_i    (out_ready),
    .rd_o           (rd_out),
    .result_o       (result),
    .reg_write_o    (reg_write),
    .redirect_o     (redirect),
    .redirect_tgt_o (redirect_tgt),
    .misalign_o     (misalign)
  );

  // ==========================================================
  // Helpers
  // ==========================================================

  function automatic logic [31:0] vec_field(input int vec, input int col);
    return vec_mem[vec * num_cols + col];
  endfunction

  task automatic abort_run(input string reason);
    $display("=== FAIL ===");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_xlen(input string name, input xlen_t exp_v, input xlen_t act_v);
    if (act_v !== exp_v) begin
      $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
      abort_run("output value mismatch");
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t exp_v,
                                input reg_addr_t act_v);
    if (act_v !== exp_v) begin
      $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
      abort_run("output value mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
      abort_run("output value mismatch");
    end
  endtask

  // Prefill marks any vector slot the file did not reach
  task automatic load_vectors();
    for (int i = 0; i < num_vecs * num_cols; i++) begin
      vec_mem[i] = '1;
    end
    $readmemh("bench/ex_tests.mem", vec_mem);
    for (int v = 0; v < num_vecs; v++) begin
      if (vec_field(v, c_op) > 32'd7) begin
        $display("Vector file is missing or holds fewer than %0d vectors", num_vecs);
        abort_run("bad vector file");
      end
    end
  endtask

  task automatic drive_vector(input int idx);
    in_valid  = 1'b1;
    op_kind   = op_kind_t'(3'(vec_field(idx, c_op)));
    funct3    = funct3_t'(3'(vec_field(idx, c_f3)));
    funct7_b5 = 1'(vec_field(idx, c_f7));
    rd_in     = `EX_REG_ADDR_W'(vec_field(idx, c_rd));
    rs1_data  = vec_field(idx, c_rs1);
    rs2_data  = vec_field(idx, c_rs2);
    imm       = vec_field(idx, c_imm);
    pc        = vec_field(idx, c_pc);
  endtask

  // Runs 2 ns after each rising edge and is the only user of the seed
  task automatic step_inputs();
    logic [31:0] r;
    r = $random(seed);
    if (in_fire) begin
      exp_q.push_back(next_idx);
      next_idx++;
    end
    // A stalled offer keeps its fields
    if (in_valid && !in_fire) begin
      in_valid = 1'b1;
    end else if (next_idx < num_vecs && r[3:2] != 2'b00) begin
      drive_vector(next_idx);
    end else begin
      in_valid = 1'b0;
    end
    // Back-pressure in about one cycle of four
    out_ready = (r[1:0] != 2'b00);
  endtask

  task automatic compare_result(input int idx);
    op_kind_t k;
    k = op_kind_t'(3'(vec_field(idx, c_op)));
    check_reg_addr("rd_o", `EX_REG_ADDR_W'(vec_field(idx, c_rd)), rd_out);
    // Branch result bus carries no meaning
    if (k != OP_BRANCH) begin
      check_xlen("result_o", vec_field(idx, c_res), result);
    end
    check_flag("reg_write_o", 1'(vec_field(idx, c_wr)), reg_write);
    check_flag("redirect_o", 1'(vec_field(idx, c_redir)), redirect);
    if (vec_field(idx, c_redir) != 32'd0) begin
      check_xlen("redirect_tgt_o", vec_field(idx, c_tgt), redirect_tgt);
    end
    check_flag("misalign_o", 1'(vec_field(idx, c_mis)), misalign);
  endtask

  // Sampled at the falling edge once all outputs have settled
  task automatic watch_output();
    int idx;
    if (stalled) begin
      check_flag("out_valid_o (held)", 1'b1, out_valid);
      check_reg_addr("rd_o (held)", held_rd, rd_out);
      check_xlen("result_o (held)", held_result, result);
      check_flag("reg_write_o (held)", held_wr, reg_write);
      check_flag("redirect_o (held)", held_redir, redirect);
      check_xlen("redirect_tgt_o (held)", held_tgt, redirect_tgt);
      check_flag("misalign_o (held)", held_mis, misalign);
    end
    if (out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("A result left the stage with no instruction outstanding");
        abort_run("unexpected output transfer");
      end else begin
        idx = exp_q.pop_front();
        compare_result(idx);
        checked++;
      end
    end
    stalled     = out_valid && !out_ready;
    held_rd     = rd_out;
    held_result = result;
    held_wr     = reg_write;
    held_redir  = redirect;
    held_tgt    = redirect_tgt;
    held_mis    = misalign;
  endtask

  // ==========================================================
  // Processes
  // ==========================================================

  initial begin : run_tests
    in_valid  = 1'b0;
    op_kind   = OP_ALU_REG;
    funct3    = '0;
    funct7_b5 = 1'b0;
    rd_in     = '0;
    rs1_data  = '0;
    rs2_data  = '0;
    imm       = '0;
    pc        = '0;
    out_ready = 1'b0;
    next_idx  = 0;
    checked   = 0;
    in_fire   = 1'b0;
    stalled   = 1'b0;
    load_vectors();

    // Idle outputs through reset and one cycle past it
    repeat (2) @(posedge clk);
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      check_flag("out_valid_o", 1'b0, out_valid);
      check_flag("in_ready_o", 1'b1, in_ready);
    end

    while (checked < num_vecs) begin
      @(posedge clk);
      #2;
      step_inputs();
    end
    // Extra cycles catch duplicated results
    repeat (8) begin
      @(posedge clk);
      #2;
      step_inputs();
    end

    // Both stages drained once every result has left
    @(negedge clk);
    if (out_valid === 1'b0 && in_ready === 1'b1) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("Stage still holds an item after all %0d results were checked", num_vecs);
      abort_run("stage not idle at end of run");
    end
  end

  initial begin : monitor
    forever begin
      @(negedge clk);
      in_fire = in_valid && in_ready;
      if (rst_n === 1'b1) begin
        watch_output();
      end
    end
  end

  initial begin : watchdog
    wait (rst_n === 1'b1);
    repeat (timeout_cycles) @(posedge clk);
    $display("Timed out after %0d cycles before all results arrived", timeout_cycles);
    abort_run("watchdog timeout");
  end

endmodule

`default_nettype wire

// ==== bench/ex_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_clock_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Reset released just after the last reset edge
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== hdl/ex_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top (
  input  logic              clk,
  input  logic              rst_n,

  // Decoded instruction in
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  ex_pkg::op_kind_t  op_kind_i,
  input  ex_pkg::funct3_t   funct3_i,
  input  logic              funct7_b5_i,
  input  ex_pkg::reg_addr_t rd_i,
  input  ex_pkg::xlen_t     rs1_data_i,
  input  ex_pkg::xlen_t     rs2_data_i,
  input  ex_pkg::xlen_t     imm_i,
  input  ex_pkg::xlen_t     pc_i,

  // Result out, held under back-pressure
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output ex_pkg::reg_addr_t rd_o,
  output ex_pkg::xlen_t     result_o,
  output logic              reg_write_o,
  output logic              redirect_o,
  output ex_pkg::xlen_t     redirect_tgt_o,
  output logic              misalign_o
);

  // ==========================================================
  // Internal buses
  // ==========================================================

  ex_op_if  op_bus ();
  ex_div_if div_bus ();

  // ==========================================================
  // Stages
  // ==========================================================

  // Decode and operand select, one register deep
  ex_issue u_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_kind_i   (op_kind_i),
    .funct3_i    (funct3_i),
    .funct7_b5_i (funct7_b5_i),
    .rd_i        (rd_i),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .imm_i       (imm_i),
    .pc_i        (pc_i),
    .op_o        (op_bus)
  );

  // ALU, branch and jump resolution, output register
  ex_compute u_compute (
    .clk            (clk),
    .rst_n          (rst_n),
    .op_i           (op_bus),
    .div_o          (div_bus),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .rd_o           (rd_o),
    .result_o       (result_o),
    .reg_write_o    (reg_write_o),
    .redirect_o     (redirect_o),
    .redirect_tgt_o (redirect_tgt_o),
    .misalign_o     (misalign_o)
  );

  // Sequential divide and remainder
  ex_divider u_divider (
    .clk   (clk),
    .rst_n (rst_n),
    .div_i (div_bus)
  );

endmodule

`default_nettype wire

// ==== hdl/ex_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_divider (
  input  logic   clk,
  input  logic   rst_n,
  ex_div_if.unit div_i
);
  import ex_pkg::*;

  localparam int cnt_w = $clog2(`EX_DIV_STEPS + 1);

  logic               busy_q;
  logic [cnt_w-1:0]   count_q;
  logic               launch;
  // Quotient shifts in from the bottom as dividend bits leave the top
  xlen_t              quo_q;
  xlen_t              rem_q;
  xlen_t              dvsr_q;
  xlen_t              dividend_q;
  logic               neg_quo_q;
  logic               neg_rem_q;
  logic               zero_q;
  logic               ovf_q;
  logic               rem_sel_q;
  logic               sign_a;
  logic               sign_b;
  xlen_t              mag_a;
  xlen_t              mag_b;
  logic [`EX_XLEN:0]  rem_shift;
  logic [`EX_XLEN:0]  rem_sub;
  logic               fits;
  xlen_t              quo_fix;
  xlen_t              rem_fix;

  assign launch = div_i.start && !busy_q;

  // Operand magnitudes, signs only count for DIV and REM
  assign sign_a = div_i.is_signed && div_i.dividend[`EX_XLEN-1];
  assign sign_b = div_i.is_signed && div_i.divisor[`EX_XLEN-1];
  assign mag_a  = sign_a ? -div_i.dividend : div_i.dividend;
  assign mag_b  = sign_b ? -div_i.divisor : div_i.divisor;

  // ==========================================================
  // Restoring step
  // ==========================================================

  assign rem_shift = {rem_q, quo_q[`EX_XLEN-1]};
  assign rem_sub   = rem_shift - {1'b0, dvsr_q};
  assign fits      = rem_shift >= {1'b0, dvsr_q};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      count_q <= '0;
    end else if (launch) begin
      busy_q  <= 1'b1;
      count_q <= cnt_w'(`EX_DIV_STEPS);
    end else if (busy_q) begin
      count_q <= count_q - 1'b1;
      // Last step lands on the same edge busy drops
      if (count_q == cnt_w'(1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      quo_q      <= mag_a;
      rem_q      <= '0;
      dvsr_q     <= mag_b;
      dividend_q <= div_i.dividend;
      neg_quo_q  <= sign_a ^ sign_b;
      neg_rem_q  <= sign_a;
      zero_q     <= div_i.divisor == '0;
      // Most negative value over minus one
      ovf_q      <= div_i.is_signed && (div_i.dividend == {1'b1, {(`EX_XLEN-1){1'b0}}})
                    && (div_i.divisor == '1);
      rem_sel_q  <= div_i.want_rem;
    end else if (busy_q) begin
      quo_q <= {quo_q[`EX_XLEN-2:0], fits};
      rem_q <= fits ? rem_sub[`EX_XLEN-1:0] : rem_shift[`EX_XLEN-1:0];
    end
  end

  // ==========================================================
  // Sign fix-up and RISC-V special cases
  // ==========================================================

  // Remainder takes the dividend's sign
  assign quo_fix = neg_quo_q ? -quo_q : quo_q;
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;

  always_comb begin
    if (zero_q) begin
      div_i.result = rem_sel_q ? dividend_q : '1;
    end else if (ovf_q) begin
      div_i.result = rem_sel_q ? '0 : dividend_q;
    end else begin
      div_i.result = rem_sel_q ? rem_fix : quo_fix;
    end
  end

  assign div_i.busy = busy_q;

endmodule

`default_nettype wire

// ==== hdl/ex_compute.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_compute (
  input  logic              clk,
  input  logic              rst_n,
  ex_op_if.compute          op_i,
  ex_div_if.ctrl            div_o,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output ex_pkg::reg_addr_t rd_o,
  output ex_pkg::xlen_t     result_o,
  output logic              reg_write_o,
  output logic              redirect_o,
  output ex_pkg::xlen_t     redirect_tgt_o,
  output logic              misalign_o
);
  import ex_pkg::*;

  localparam int shamt_w = $clog2($bits(xlen_t));

  div_state_t          state_q;
  div_state_t          state_d;
  logic                out_valid_q;
  logic                out_free;
  logic                op_take;
  logic                is_div;
  logic                div_start;
  logic                load_alu;
  logic                load_div;
  reg_addr_t           div_rd_q;
  logic [shamt_w-1:0]  shamt;
  xlen_t               alu_res;
  logic                br_taken;
  logic                is_jump;
  logic                redirect;
  logic                misalign;
  logic                writes_reg;
  xlen_t               pc_rel_tgt;
  xlen_t               jalr_tgt;
  xlen_t               tgt;
  xlen_t               link;

  // ==========================================================
  // Handshake and divider launch
  // ==========================================================

  // Output slot empty or draining this cycle
  assign out_free    = !out_valid_q || out_ready_i;
  // Blocked for the whole divide so ordering is kept
  assign op_i.ready  = (state_q == DIV_IDLE) && out_free;
  assign op_take     = op_i.valid && op_i.ready;
  assign is_div      = op_i.op_kind == OP_DIV;
  assign div_start   = op_take && is_div;
  assign load_alu    = op_take && !is_div;
  assign load_div    = (state_q == DIV_DONE) && out_free;

  assign div_o.start     = div_start;
  // funct3 100 DIV, 101 DIVU, 110 REM, 111 REMU
  assign div_o.is_signed = !op_i.funct3[0];
  assign div_o.want_rem  = op_i.funct3[1];
  assign div_o.dividend  = op_i.a;
  assign div_o.divisor   = op_i.b;

  // ==========================================================
  // ALU
  // ==========================================================

  assign shamt = op_i.b[shamt_w-1:0];

  always_comb begin
    alu_res = '0;
    case (op_i.alu_op)
      ALU_SUB:  alu_res = op_i.a - op_i.b;
      ALU_SLL:  alu_res = op_i.a << shamt;
      ALU_SLT:  alu_res[0] = $signed(op_i.a) < $signed(op_i.b);
      ALU_SLTU: alu_res[0] = op_i.a < op_i.b;
      ALU_XOR:  alu_res = op_i.a ^ op_i.b;
      ALU_SRL:  alu_res = op_i.a >> shamt;
      ALU_SRA:  alu_res = $signed(op_i.a) >>> shamt;
      ALU_OR:   alu_res = op_i.a | op_i.b;
      ALU_AND:  alu_res = op_i.a & op_i.b;
      default:  alu_res = op_i.a + op_i.b;
    endcase
  end

  // ==========================================================
  // Branch compare, targets and link
  // ==========================================================

  always_comb begin
    case (op_i.funct3)
      3'b000:  br_taken = op_i.a == op_i.b;
      3'b001:  br_taken = op_i.a != op_i.b;
      3'b100:  br_taken = $signed(op_i.a) < $signed(op_i.b);
      3'b101:  br_taken = $signed(op_i.a) >= $signed(op_i.b);
      3'b110:  br_taken = op_i.a < op_i.b;
      3'b111:  br_taken = op_i.a >= op_i.b;
      // 010 and 011 are not branch encodings
      default: br_taken = 1'b0;
    endcase
  end

  // Branches and JAL are pc relative
  assign pc_rel_tgt = op_i.pc + op_i.imm;
  // JALR uses the rs1+imm sum with bit 0 dropped
  assign jalr_tgt   = {alu_res[$bits(xlen_t)-1:1], 1'b0};
  assign tgt        = (op_i.op_kind == OP_JALR) ? jalr_tgt : pc_rel_tgt;
  assign link       = op_i.pc + 32'd4;

  assign is_jump    = (op_i.op_kind == OP_JAL) || (op_i.op_kind == OP_JALR);
  assign redirect   = ((op_i.op_kind == OP_BRANCH) && br_taken) || is_jump;
  // Targets must be word aligned without compressed support
  assign misalign   = redirect && (|tgt[1:0]);
  assign writes_reg = op_i.op_kind != OP_BRANCH;

  // ==========================================================
  // Divide sequencing FSM
  // ==========================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      DIV_IDLE: begin
        if (div_start) begin
          state_d = DIV_RUN;
        end
      end
      // Busy is already high in the first RUN cycle
      DIV_RUN: begin
        if (!div_o.busy) begin
          state_d = DIV_DONE;
        end
      end
      // Wait here until the output slot can take the result
      DIV_DONE: begin
        if (out_free) begin
          state_d = DIV_IDLE;
        end
      end
      default: state_d = DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Destination of the divide in flight
  always_ff @(posedge clk) begin
    if (div_start) begin
      div_rd_q <= op_i.rd;
    end
  end

  // ==========================================================
  // Output register
  // ==========================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (load_alu || load_div) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_alu) begin
      rd_o           <= op_i.rd;
      result_o       <= is_jump ? link : alu_res;
      reg_write_o    <= writes_reg && (|op_i.rd) && !misalign;
      redirect_o     <= redirect;
      redirect_tgt_o <= tgt;
      misalign_o     <= misalign;
    end else if (load_div) begin
      rd_o           <= div_rd_q;
      result_o       <= div_o.result;
      reg_write_o    <= |div_rd_q;
      redirect_o     <= 1'b0;
      redirect_tgt_o <= '0;
      misalign_o     <= 1'b0;
    end
  end

  assign out_valid_o = out_valid_q;

endmodule

`default_nettype wire

// ==== hdl/ex_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_issue (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  ex_pkg::op_kind_t  op_kind_i,
  input  ex_pkg::funct3_t   funct3_i,
  input  logic              funct7_b5_i,
  input  ex_pkg::reg_addr_t rd_i,
  input  ex_pkg::xlen_t     rs1_data_i,
  input  ex_pkg::xlen_t     rs2_data_i,
  input  ex_pkg::xlen_t     imm_i,
  input  ex_pkg::xlen_t     pc_i,
  ex_op_if.issue            op_o
);
  import ex_pkg::*;

  logic    valid_q;
  logic    accept;
  alu_op_t alu_op_d;
  xlen_t   a_d;
  xlen_t   b_d;

  // ==========================================================
  // Handshake
  // ==========================================================

  // Free when empty or when compute drains the slot this cycle
  assign in_ready_o = !valid_q || op_o.ready;
  assign accept     = in_valid_i && in_ready_o;
  assign op_o.valid = valid_q;

  // ==========================================================
  // ALU operation decode
  // ==========================================================

  always_comb begin
    // Address math for LUI, AUIPC, JALR and don't-care kinds
    alu_op_d = ALU_ADD;
    if (op_kind_i == OP_ALU_REG || op_kind_i == OP_ALU_IMM) begin
      case (funct3_i)
        // SUB exists only in register form, ADDI ignores bit 30
        3'b000: alu_op_d = (op_kind_i == OP_ALU_REG && funct7_b5_i) ? ALU_SUB : ALU_ADD;
        3'b001: alu_op_d = ALU_SLL;
        3'b010: alu_op_d = ALU_SLT;
        3'b011: alu_op_d = ALU_SLTU;
        3'b100: alu_op_d = ALU_XOR;
        // Arithmetic shift for both SRA and SRAI
        3'b101: alu_op_d = funct7_b5_i ? ALU_SRA : ALU_SRL;
        3'b110: alu_op_d = ALU_OR;
        default: alu_op_d = ALU_AND;
      endcase
    end
  end

  // ==========================================================
  // Operand select
  // ==========================================================

  always_comb begin
    case (op_kind_i)
      OP_ALU_IMM, OP_JALR: begin
        a_d = rs1_data_i;
        b_d = imm_i;
      end
      OP_LUI: begin
        a_d = '0;
        b_d = imm_i;
      end
      OP_AUIPC: begin
        a_d = pc_i;
        b_d = imm_i;
      end
      // Register ALU, branch compare and divide use rs1/rs2
      default: begin
        a_d = rs1_data_i;
        b_d = rs2_data_i;
      end
    endcase
  end

  // ==========================================================
  // Stage register
  // ==========================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload loads only on an accepted transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      op_o.op_kind <= op_kind_i;
      op_o.alu_op  <= alu_op_d;
      op_o.funct3  <= funct3_i;
      op_o.rd      <= rd_i;
      op_o.a       <= a_d;
      op_o.b       <= b_d;
      op_o.pc      <= pc_i;
      op_o.imm     <= imm_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ex_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// ==========================================================
// Issue to compute, one decoded op per valid/ready transfer
// ==========================================================

interface ex_op_if;
  import ex_pkg::*;

  logic      valid;
  logic      ready;
  op_kind_t  op_kind;
  alu_op_t   alu_op;
  funct3_t   funct3;
  reg_addr_t rd;
  // Selected ALU operands
  xlen_t     a;
  xlen_t     b;
  // Kept for branch target and link value
  xlen_t     pc;
  xlen_t     imm;

  modport issue (output valid, op_kind, alu_op, funct3, rd, a, b, pc, imm, input ready);
  modport compute (input valid, op_kind, alu_op, funct3, rd, a, b, pc, imm, output ready);
endinterface

// ==========================================================
// Compute to divider, start pulse and busy/result return
// ==========================================================

interface ex_div_if;
  import ex_pkg::*;

  logic  start;
  logic  is_signed;
  logic  want_rem;
  xlen_t dividend;
  xlen_t divisor;
  logic  busy;
  // Valid from busy falling until next start
  xlen_t result;

  modport ctrl (output start, is_signed, want_rem, dividend, divisor, input busy, result);
  modport unit (input start, is_signed, want_rem, dividend, divisor, output busy, result);
endinterface

`default_nettype wire

// ==== hdl/ex_pkg.sv ====
`default_nettype none

`include "ex_defs.svh"

package ex_pkg;

  // ==========================================================
  // Width types
  // ==========================================================

  // Data word for operands, results, pc and targets
  typedef logic [`EX_XLEN-1:0] xlen_t;

  // Destination register index
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

  // Selects ALU op, branch condition or divide kind
  typedef logic [2:0] funct3_t;

  // ==========================================================
  // Enumerations
  // ==========================================================

  // Instruction class as seen by the execute stage
  typedef enum logic [2:0] {
    OP_ALU_REG = 3'd0,
    OP_ALU_IMM = 3'd1,
    OP_LUI     = 3'd2,
    OP_AUIPC   = 3'd3,
    OP_BRANCH  = 3'd4,
    OP_JAL     = 3'd5,
    OP_JALR    = 3'd6,
    OP_DIV     = 3'd7
  } op_kind_t;

  // ALU function, decoded in the issue stage
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  // Divide sequencing in the compute stage
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_RUN  = 2'd1,
    DIV_DONE = 2'd2
  } div_state_t;

endpackage

`default_nettype wire

// ==== hdl/ex_defs.svh ====
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// ==========================================================
// Execute stage sizing
// ==========================================================

// Width of operands, results, pc and targets
`define EX_XLEN 32

// Destination register index width
`define EX_REG_ADDR_W 5

// One restoring iteration per quotient bit
`define EX_DIV_STEPS `EX_XLEN

`endif
